// ==== Bender.yml ====
package:
  name: aes_wb

sources:
  - src/aes_pkg.sv
  - src/aes_sub_bytes.sv
  - src/aes_mix_cols.sv
  - src/aes_round.sv
  - src/aes_key_expand.sv
  - src/aes_ctrl.sv
  - src/aes_wb_regs.sv
  - src/aes_top.sv
  - target: simulation
    files:
      - verif/aes_tb_clk.sv
      - verif/aes_tb_assert.sv
      - verif/aes_tb.sv

// ==== files.f ====
src/aes_pkg.sv
src/aes_sub_bytes.sv
src/aes_mix_cols.sv
src/aes_round.sv
src/aes_key_expand.sv
src/aes_ctrl.sv
src/aes_wb_regs.sv
src/aes_top.sv
verif/aes_tb_clk.sv
verif/aes_tb_assert.sv
verif/aes_tb.sv

// ==== src/aes_ctrl.sv ====
`timescale 1ns/1ps

module aes_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic load,
    output logic round_en,
    output logic last_round,
    output logic busy,
    output logic done
);

    aes_pkg::aes_state_e state_q;
    aes_pkg::aes_state_e state_d;

    // counts rounds already issued, 0 to 9
    logic [3:0] round_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q <= aes_pkg::IDLE;
            round_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (load)
                round_q <= '0;
            else if (round_en)
                round_q <= round_q + 4'd1;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            // a start outside idle is dropped here
            aes_pkg::IDLE:  if (start) state_d = aes_pkg::LOAD;
            aes_pkg::LOAD:  state_d = aes_pkg::ROUND;
            aes_pkg::ROUND: if (last_round) state_d = aes_pkg::DONE;
            aes_pkg::DONE:  state_d = aes_pkg::IDLE;
            default:        state_d = aes_pkg::IDLE;
        endcase
    end

    // outputs decode straight from the state register
    assign load       = (state_q == aes_pkg::LOAD);
    assign round_en   = (state_q == aes_pkg::ROUND);
    assign last_round = round_en && (round_q == 4'(aes_pkg::AES_ROUNDS - 1));
    // load plus ten rounds
    assign busy       = load || round_en;
    assign done       = (state_q == aes_pkg::DONE);

endmodule

// ==== src/aes_key_expand.sv ====
`timescale 1ns/1ps

module aes_key_expand (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         load,
    input  logic         round_en,
    input  logic [127:0] key,
    output logic [127:0] round_key
);

    // current round key and its round constant
    logic [127:0] rk_q;
    logic [7:0]   rcon_q;

    logic [31:0]  w3_rot;
    logic [127:0] sub_out;
    logic [31:0]  temp;
    logic [31:0]  n0;
    logic [31:0]  n1;
    logic [31:0]  n2;
    logic [31:0]  n3;

    // rotword of the last word
    assign w3_rot = {rk_q[23:0], rk_q[31:24]};

    // subword, only the low lane carries data
    aes_sub_bytes u_sub_word (
        .data   ({96'h0, w3_rot}),
        .result (sub_out)
    );

    assign temp = sub_out[31:0] ^ {rcon_q, 24'h0};

    // each new word chains off the one before it
    assign n0 = rk_q[127:96] ^ temp;
    assign n1 = rk_q[95:64] ^ n0;
    assign n2 = rk_q[63:32] ^ n1;
    assign n3 = rk_q[31:0] ^ n2;

    // next round key, used by the round datapath in the same cycle
    assign round_key = {n0, n1, n2, n3};

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rk_q   <= '0;
            rcon_q <= 8'h01;
        end
        else if (load)
        begin
            rk_q   <= key;
            rcon_q <= 8'h01;
        end
        else if (round_en)
        begin
            rk_q   <= round_key;
            // 01, 02, ... 80, 1b, 36
            rcon_q <= aes_pkg::aes_xtime(rcon_q);
        end
    end

endmodule

// ==== src/aes_mix_cols.sv ====
`timescale 1ns/1ps

module aes_mix_cols (
    input  logic [127:0] data,
    output logic [127:0] result
);

    genvar c;
    generate
        for (c = 0; c < 4; c++)
        begin : g_col
            // column c sits at bits [127-32c -: 32], row 0 in the top byte
            logic [7:0] s0;
            logic [7:0] s1;
            logic [7:0] s2;
            logic [7:0] s3;
            // times 2 of each row byte
            logic [7:0] d0;
            logic [7:0] d1;
            logic [7:0] d2;
            logic [7:0] d3;

            assign s0 = data[127 - 32*c -: 8];
            assign s1 = data[119 - 32*c -: 8];
            assign s2 = data[111 - 32*c -: 8];
            assign s3 = data[103 - 32*c -: 8];

            assign d0 = aes_pkg::aes_xtime(s0);
            assign d1 = aes_pkg::aes_xtime(s1);
            assign d2 = aes_pkg::aes_xtime(s2);
            assign d3 = aes_pkg::aes_xtime(s3);

            // circulant 2,3,1,1 where times 3 is times 2 xor self
            assign result[127 - 32*c -: 8] = d0 ^ (d1 ^ s1) ^ s2 ^ s3;
            assign result[119 - 32*c -: 8] = s0 ^ d1 ^ (d2 ^ s2) ^ s3;
            assign result[111 - 32*c -: 8] = s0 ^ s1 ^ d2 ^ (d3 ^ s3);
            assign result[103 - 32*c -: 8] = (d0 ^ s0) ^ s1 ^ s2 ^ d3;
        end
    endgenerate

endmodule

// ==== src/aes_pkg.sv ====
package aes_pkg;

    // encryption FSM states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        ROUND = 2'd2,
        DONE  = 2'd3
    } aes_state_e;

    // wishbone word map, key and plaintext word 0 is the most significant
    typedef enum logic [3:0] {
        KEY0   = 4'd0,
        KEY1   = 4'd1,
        KEY2   = 4'd2,
        KEY3   = 4'd3,
        PT0    = 4'd4,
        PT1    = 4'd5,
        PT2    = 4'd6,
        PT3    = 4'd7,
        CTRL   = 4'd8,
        STATUS = 4'd9,
        CT0    = 4'd12,
        CT1    = 4'd13,
        CT2    = 4'd14,
        CT3    = 4'd15
    } aes_reg_e;

    // aes-128 round count
    localparam int unsigned AES_ROUNDS = 10;

    // multiply by 2, reduce by the low byte of x^8+x^4+x^3+x+1
    function automatic logic [7:0] aes_xtime(input logic [7:0] x);
        return x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
    endfunction

    // shift and add multiply in gf(2^8)
    function automatic logic [7:0] aes_gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] t;
        p = 8'h00;
        t = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ t;
            t = aes_xtime(t);
        end
        return p;
    endfunction

    // inverse as x^254 (zero maps to zero), then the affine transform
    function automatic logic [7:0] aes_sbox(input logic [7:0] x);
        logic [7:0] inv;
        logic [7:0] base;
        inv  = 8'h01;
        base = x;
        // exponent 254 is 8'b1111_1110
        for (int i = 1; i < 8; i++)
        begin
            base = aes_gmul(base, base);
            inv  = aes_gmul(inv, base);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
               {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

endpackage

// ==== src/aes_round.sv ====
`timescale 1ns/1ps

module aes_round (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         load,
    input  logic         round_en,
    input  logic         last_round,
    input  logic [127:0] plaintext,
    input  logic [127:0] key,
    input  logic [127:0] round_key,
    output logic [127:0] state
);

    logic [127:0] sub_out;
    logic [127:0] shift_out;
    logic [127:0] mix_out;
    logic [127:0] round_out;

    aes_sub_bytes u_sub_bytes (
        .data   (state),
        .result (sub_out)
    );

    // shiftrows, row r rotates left by r columns
    // byte (r,c) lives at bits [127 - 8*(4c+r) -: 8]
    genvar r, c;
    generate
        for (r = 0; r < 4; r++)
        begin : g_row
            for (c = 0; c < 4; c++)
            begin : g_col
                assign shift_out[127 - 8*(4*c + r) -: 8] =
                    sub_out[127 - 8*(4*((c + r) % 4) + r) -: 8];
            end
        end
    endgenerate

    aes_mix_cols u_mix_cols (
        .data   (shift_out),
        .result (mix_out)
    );

    // final round has no mixcolumns
    assign round_out = (last_round ? shift_out : mix_out) ^ round_key;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= '0;
        else if (load)
            // initial addroundkey
            state <= plaintext ^ key;
        else if (round_en)
            state <= round_out;
    end

endmodule

// ==== src/aes_sub_bytes.sv ====
`timescale 1ns/1ps

module aes_sub_bytes (
    input  logic [127:0] data,
    output logic [127:0] result
);

    // one s-box per byte, all sixteen in parallel
    genvar i;
    generate
        for (i = 0; i < 16; i++)
        begin : g_sbox
            // byte order does not matter here, each lane is independent
            assign result[8*i +: 8] = aes_pkg::aes_sbox(data[8*i +: 8]);
        end
    endgenerate

endmodule

// ==== src/aes_top.sv ====
`timescale 1ns/1ps

module aes_top #(
    parameter int WB_ADR_WIDTH = 4
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [WB_ADR_WIDTH-1:0] wb_adr,
    input  logic [31:0]             wb_wdata,
    output logic [31:0]             wb_rdata,
    output logic                    wb_ack
);

    // bus side
    logic         start;
    logic [127:0] key;
    logic [127:0] plaintext;
    // control strobes
    logic         load;
    logic         round_en;
    logic         last_round;
    logic         busy;
    logic         done;
    // datapath
    logic [127:0] round_key;
    logic [127:0] state;

    aes_wb_regs #(
        .WB_ADR_WIDTH (WB_ADR_WIDTH)
    ) u_wb_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .busy      (busy),
        .done      (done),
        .state     (state),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .start     (start),
        .key       (key),
        .plaintext (plaintext)
    );

    aes_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .load       (load),
        .round_en   (round_en),
        .last_round (last_round),
        .busy       (busy),
        .done       (done)
    );

    // state and round key step in lockstep
    aes_round u_round (
        .clk        (clk),
        .arst_n     (arst_n),
        .load       (load),
        .round_en   (round_en),
        .last_round (last_round),
        .plaintext  (plaintext),
        .key        (key),
        .round_key  (round_key),
        .state      (state)
    );

    aes_key_expand u_key_expand (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load),
        .round_en  (round_en),
        .key       (key),
        .round_key (round_key)
    );

endmodule

// ==== src/aes_wb_regs.sv ====
`timescale 1ns/1ps

module aes_wb_regs #(
    parameter int WB_ADR_WIDTH = 4
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [WB_ADR_WIDTH-1:0] wb_adr,
    input  logic [31:0]             wb_wdata,
    input  logic                    busy,
    input  logic                    done,
    input  logic [127:0]            state,
    output logic [31:0]             wb_rdata,
    output logic                    wb_ack,
    output logic                    start,
    output logic [127:0]            key,
    output logic [127:0]            plaintext
);

    logic                req;
    logic                hit;
    aes_pkg::aes_reg_e   reg_sel;
    logic [31:0]         key_w [4];
    logic [31:0]         pt_w [4];
    logic [127:0]        ct_q;
    // sticky done, cleared once a new run is underway
    logic                done_q;
    logic [31:0]         rd_mux;

    // new request, the ack cycle itself is not a second request
    assign req = wb_cyc && wb_stb && !wb_ack;

    // upper address bits must be zero
    assign hit     = ((wb_adr >> 4) == '0);
    assign reg_sel = aes_pkg::aes_reg_e'(wb_adr[3:0]);

    assign key       = {key_w[0], key_w[1], key_w[2], key_w[3]};
    assign plaintext = {pt_w[0], pt_w[1], pt_w[2], pt_w[3]};

    always_comb
    begin
        rd_mux = 32'h0;
        if (hit)
        begin
            case (reg_sel)
                aes_pkg::KEY0, aes_pkg::KEY1,
                aes_pkg::KEY2, aes_pkg::KEY3: rd_mux = key_w[wb_adr[1:0]];
                aes_pkg::PT0, aes_pkg::PT1,
                aes_pkg::PT2, aes_pkg::PT3:   rd_mux = pt_w[wb_adr[1:0]];
                // a stale done stays hidden while the next run is loading
                aes_pkg::STATUS:              rd_mux = {30'h0, done_q && !busy, busy};
                // ct0 is the top word
                aes_pkg::CT0, aes_pkg::CT1,
                aes_pkg::CT2, aes_pkg::CT3:   rd_mux = ct_q[127 - 32*wb_adr[1:0] -: 32];
                default:                      rd_mux = 32'h0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_ack   <= 1'b0;
            wb_rdata <= '0;
            start    <= 1'b0;
            done_q   <= 1'b0;
            ct_q     <= '0;
            for (int i = 0; i < 4; i++)
            begin
                key_w[i] <= '0;
                pt_w[i]  <= '0;
            end
        end
        else
        begin
            // single cycle ack, never stalls
            wb_ack <= req;
            start  <= req && wb_we && hit && (reg_sel == aes_pkg::CTRL) && wb_wdata[0];
            if (req && !wb_we)
                wb_rdata <= rd_mux;
            // operand writes during a run are acked and dropped
            if (req && wb_we && hit && !busy)
            begin
                case (reg_sel)
                    aes_pkg::KEY0, aes_pkg::KEY1,
                    aes_pkg::KEY2, aes_pkg::KEY3: key_w[wb_adr[1:0]] <= wb_wdata;
                    aes_pkg::PT0, aes_pkg::PT1,
                    aes_pkg::PT2, aes_pkg::PT3:   pt_w[wb_adr[1:0]] <= wb_wdata;
                    default:                      ;
                endcase
            end
            // busy only rises after an accepted start
            if (done)
            begin
                done_q <= 1'b1;
                ct_q   <= state;
            end
            else if (busy)
                done_q <= 1'b0;
        end
    end

endmodule

// ==== verif/aes_tb.sv ====
`timescale 1ns/1ps

module aes_tb;

    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 40;
    localparam int N_RANDOM   = 30;

    // fips-197 appendix b
    localparam logic [127:0] FIPS_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [127:0] FIPS_PT  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam logic [127:0] FIPS_CT  = 128'h3925841d02dc09fbdc118597196a0b32;

    logic         clk;
    logic         arst_n;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    logic [3:0]   wb_adr;
    logic [31:0]  wb_wdata;
    logic [31:0]  wb_rdata;
    logic         wb_ack;

    integer       seed;
    int           errors;
    int           errors_at_start;
    int           tests_run;
    int           tests_failed;
    string        test_name;
    logic [7:0]   sbox_tbl [256];
    // expected ciphertext of the most recent finished run
    logic [127:0] last_ct;

    aes_tb_clk #(
        .PERIOD_NS (100)
    ) u_clk (
        .clk (clk)
    );

    aes_top #(
        .WB_ADR_WIDTH (4)
    ) uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    bind aes_top aes_tb_assert u_assert (
        .clk    (clk),
        .arst_n (arst_n),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_ack (wb_ack),
        .start  (start),
        .busy   (busy),
        .done   (done)
    );

    function automatic logic [7:0] gf_double(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // walk the group with generator 3, q tracks the inverse of p
    task automatic build_sbox;
        logic [7:0] p;
        logic [7:0] q;
        logic [7:0] x;
        p = 8'h01;
        q = 8'h01;
        do
        begin
            p = p ^ gf_double(p);
            // divide q by 3
            q = q ^ {q[6:0], 1'b0};
            q = q ^ {q[5:0], 2'b00};
            q = q ^ {q[3:0], 4'h0};
            if (q[7])
                q = q ^ 8'h09;
            x = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]} ^ {q[3:0], q[7:4]};
            sbox_tbl[p] = x ^ 8'h63;
        end
        while (p != 8'h01);
        sbox_tbl[0] = 8'h63;
    endtask

    // byte i of the block is s[i], column major as in fips-197
    function automatic logic [127:0] aes128_encrypt(input logic [127:0] key,
                                                    input logic [127:0] pt);
        logic [31:0]  w [44];
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [31:0]  tmp;
        logic [7:0]   rcon;
        logic [127:0] out;
        for (int i = 0; i < 4; i++)
            w[i] = key[127 - 32*i -: 32];
        rcon = 8'h01;
        for (int i = 4; i < 44; i++)
        begin
            tmp = w[i-1];
            if (i % 4 == 0)
            begin
                tmp = {sbox_tbl[tmp[23:16]], sbox_tbl[tmp[15:8]],
                       sbox_tbl[tmp[7:0]], sbox_tbl[tmp[31:24]]} ^ {rcon, 24'h0};
                rcon = gf_double(rcon);
            end
            w[i] = w[i-4] ^ tmp;
        end
        for (int i = 0; i < 16; i++)
            s[i] = pt[127 - 8*i -: 8] ^ w[i/4][31 - 8*(i%4) -: 8];
        for (int rnd = 1; rnd <= 10; rnd++)
        begin
            // subbytes and shiftrows in one pass
            for (int c = 0; c < 4; c++)
                for (int r = 0; r < 4; r++)
                    t[4*c + r] = sbox_tbl[s[4*((c + r) % 4) + r]];
            for (int c = 0; c < 4; c++)
            begin
                if (rnd == 10)
                begin
                    for (int r = 0; r < 4; r++)
                        s[4*c + r] = t[4*c + r];
                end
                else
                begin
                    s[4*c]     = gf_double(t[4*c]) ^ gf_double(t[4*c+1]) ^ t[4*c+1] ^
                                 t[4*c+2] ^ t[4*c+3];
                    s[4*c + 1] = t[4*c] ^ gf_double(t[4*c+1]) ^ gf_double(t[4*c+2]) ^
                                 t[4*c+2] ^ t[4*c+3];
                    s[4*c + 2] = t[4*c] ^ t[4*c+1] ^ gf_double(t[4*c+2]) ^
                                 gf_double(t[4*c+3]) ^ t[4*c+3];
                    s[4*c + 3] = gf_double(t[4*c]) ^ t[4*c] ^ t[4*c+1] ^ t[4*c+2] ^
                                 gf_double(t[4*c+3]);
                end
            end
            for (int i = 0; i < 16; i++)
                s[i] = s[i] ^ w[4*rnd + i/4][31 - 8*(i%4) -: 8];
        end
        for (int i = 0; i < 16; i++)
            out[127 - 8*i -: 8] = s[i];
        return out;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic report_mismatch(input string what, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    endtask

    // one classic cycle, drop stb on the negedge where ack is seen
    task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
        int cycles;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_wdata = data;
        cycles   = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!wb_ack && cycles < ACK_LIMIT);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack)
            abort_run($sformatf("write to address %0d got no ack within %0d cycles",
                                adr, ACK_LIMIT));
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
        int cycles;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!wb_ack && cycles < ACK_LIMIT);
        data   = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        if (!wb_ack)
            abort_run($sformatf("read of address %0d got no ack within %0d cycles",
                                adr, ACK_LIMIT));
    endtask

    // word 0 is the top word
    task automatic write_block(input logic [3:0] base, input logic [127:0] data);
        for (int i = 0; i < 4; i++)
            wb_write(base + 4'(i), data[127 - 32*i -: 32]);
    endtask

    task automatic read_block(input logic [3:0] base, output logic [127:0] data);
        logic [31:0] word;
        for (int i = 0; i < 4; i++)
        begin
            wb_read(base + 4'(i), word);
            data[127 - 32*i -: 32] = word;
        end
    endtask

    // poll until done is set and busy is low
    task automatic wait_done;
        logic [31:0] status;
        int polls;
        status = 32'h0;
        polls  = 0;
        while (status[1:0] != 2'b10 && polls < POLL_LIMIT)
        begin
            wb_read(aes_pkg::STATUS, status);
            polls++;
        end
        if (status[1:0] != 2'b10)
            abort_run($sformatf("encryption not done after %0d status polls", POLL_LIMIT));
    endtask

    task automatic encrypt_on_dut(input logic [127:0] key, input logic [127:0] pt,
                                  output logic [127:0] ct);
        write_block(aes_pkg::KEY0, key);
        write_block(aes_pkg::PT0, pt);
        wb_write(aes_pkg::CTRL, 32'h1);
        wait_done;
        read_block(aes_pkg::CT0, ct);
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test;
        if (errors == errors_at_start)
            $display("test %s: ok", test_name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial
    begin
        logic [127:0] key;
        logic [127:0] pt;
        logic [127:0] ct;
        logic [127:0] exp;
        logic [31:0]  word;
        logic [31:0]  word1;
        seed         = 32'h9e06_956f;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = 4'h0;
        wb_wdata     = 32'h0;
        build_sbox;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // every address reads zero out of reset
        begin_test("reset_values");
        for (int a = 0; a < 16; a++)
        begin
            wb_read(4'(a), word);
            if (word !== 32'h0)
                report_mismatch($sformatf("address %0d after reset", a), word, 0);
        end
        end_test;

        begin_test("fips_vector");
        exp = aes128_encrypt(FIPS_KEY, FIPS_PT);
        if (exp !== FIPS_CT)
            report_mismatch("reference model on the fips vector", exp, FIPS_CT);
        encrypt_on_dut(FIPS_KEY, FIPS_PT, ct);
        if (ct !== FIPS_CT)
            report_mismatch("fips ciphertext", ct, FIPS_CT);
        last_ct = FIPS_CT;
        end_test;

        begin_test("random_vectors");
        for (int n = 0; n < N_RANDOM; n++)
        begin
            key = {$random(seed), $random(seed), $random(seed), $random(seed)};
            pt  = {$random(seed), $random(seed), $random(seed), $random(seed)};
            encrypt_on_dut(key, pt, ct);
            exp = aes128_encrypt(key, pt);
            if (ct !== exp)
                report_mismatch($sformatf("random vector %0d", n), ct, exp);
            wb_read(aes_pkg::STATUS, word);
            if (word !== 32'h2)
                report_mismatch("status after a run", word, 32'h2);
            last_ct = exp;
        end
        end_test;

        begin_test("register_readback");
        key = {$random(seed), $random(seed), $random(seed), $random(seed)};
        pt  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        write_block(aes_pkg::KEY0, key);
        write_block(aes_pkg::PT0, pt);
        read_block(aes_pkg::KEY0, exp);
        if (exp !== key)
            report_mismatch("key readback", exp, key);
        read_block(aes_pkg::PT0, exp);
        if (exp !== pt)
            report_mismatch("plaintext readback", exp, pt);
        end_test;

        // five transfers of two cycles each all land inside the 11 busy cycles
        begin_test("busy_protection");
        key = {$random(seed), $random(seed), $random(seed), $random(seed)};
        pt  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        write_block(aes_pkg::KEY0, key);
        write_block(aes_pkg::PT0, pt);
        wb_write(aes_pkg::CTRL, 32'h1);
        wb_write(aes_pkg::CTRL, 32'h1);
        wb_write(aes_pkg::PT0, ~pt[127:96]);
        wb_write(aes_pkg::PT1, ~pt[95:64]);
        wb_read(aes_pkg::CT0, word);
        wb_read(aes_pkg::CT1, word1);
        if (word !== last_ct[127:96])
            report_mismatch("ct0 read while busy", word, last_ct[127:96]);
        if (word1 !== last_ct[95:64])
            report_mismatch("ct1 read while busy", word1, last_ct[95:64]);
        wait_done;
        // a second start taken after the first run would show busy here
        wb_read(aes_pkg::STATUS, word);
        if (word !== 32'h2)
            report_mismatch("status after second start", word, 32'h2);
        read_block(aes_pkg::CT0, ct);
        exp = aes128_encrypt(key, pt);
        if (ct !== exp)
            report_mismatch("ciphertext with writes during the run", ct, exp);
        last_ct = exp;
        read_block(aes_pkg::PT0, exp);
        if (exp !== pt)
            report_mismatch("plaintext after writes while busy", exp, pt);
        end_test;

        begin_test("key_reuse");
        key = {$random(seed), $random(seed), $random(seed), $random(seed)};
        write_block(aes_pkg::KEY0, key);
        for (int n = 0; n < 4; n++)
        begin
            pt = {$random(seed), $random(seed), $random(seed), $random(seed)};
            write_block(aes_pkg::PT0, pt);
            wb_write(aes_pkg::CTRL, 32'h1);
            // first read lands in the load cycle, done already reads clear
            wb_read(aes_pkg::STATUS, word);
            if (word !== 32'h1)
                report_mismatch("status early in the run", word, 32'h1);
            wait_done;
            read_block(aes_pkg::CT0, ct);
            exp = aes128_encrypt(key, pt);
            if (ct !== exp)
                report_mismatch($sformatf("key reuse run %0d", n), ct, exp);
            last_ct = exp;
        end
        end_test;

        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, uut.u_assert.fail_count);
        if (tests_failed == 0 && errors == 0 && uut.u_assert.fail_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== verif/aes_tb_assert.sv ====
`timescale 1ns/1ps

module aes_tb_assert (
    input logic clk,
    input logic arst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic start,
    input logic busy,
    input logic done
);

    // load cycle plus every round
    localparam int BUSY_CYCLES = aes_pkg::AES_ROUNDS + 1;

    // failing assertions so far, shown in the end of run summary
    int fail_count = 0;

    // length of the busy stretch in progress
    int busy_len;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            busy_len <= 0;
        else if (busy)
            busy_len <= busy_len + 1;
        else
            busy_len <= 0;
    end

    // ack answers a request seen one edge earlier
    ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else
        begin
            fail_count++;
            $error("wb_ack raised without a request on the previous cycle");
        end

    // single cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |=> !wb_ack)
        else
        begin
            fail_count++;
            $error("wb_ack held for more than one cycle");
        end

    // a start in idle must be taken
    start_taken: assert property (@(posedge clk) disable iff (!arst_n)
        (start && !busy && !done) |=> busy)
        else
        begin
            fail_count++;
            $error("start in idle did not raise busy");
        end

    // whole run is load plus ten rounds
    busy_length: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> (busy_len == BUSY_CYCLES))
        else
        begin
            fail_count++;
            $error("busy lasted %0d cycles", busy_len);
        end

    // done only in the cycle right after the last busy cycle, never alongside busy
    done_at_busy_end: assert property (@(posedge clk) disable iff (!arst_n)
        done == $fell(busy))
        else
        begin
            fail_count++;
            $error("done not aligned with the end of busy");
        end

endmodule

// ==== verif/aes_tb_clk.sv ====
`timescale 1ns/1ps

module aes_tb_clk #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // free running, low for the first half period
    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule
